//--- verilog/quant_pkg.sv
`default_nettype none

package quant_pkg;

  // ========================================
  // Widths
  // ========================================
  // Row channels per group, one per row offset
  localparam int N_CHAN   = 4;
  localparam int ACC_W    = 32;
  localparam int OUT_BITS = 8;
  localparam int MULT_W   = 16;
  localparam int SHIFT_W  = 6;

  // Full product of accumulator and scale
  localparam int PROD_W = ACC_W + MULT_W;

  // Room for the rounding term at the largest shift
  localparam int WIDE_W = 64;

  // Saturation limits of the output
  localparam int Q_MAX = 2 ** (OUT_BITS - 1) - 1;
  localparam int Q_MIN = -(2 ** (OUT_BITS - 1));

  // ========================================
  // Types
  // ========================================
  typedef logic signed [ACC_W-1:0]    acc_t;
  typedef logic signed [OUT_BITS-1:0] q_t;
  typedef logic signed [PROD_W-1:0]   prod_t;
  typedef logic signed [WIDE_W-1:0]   wide_t;

  // Requantization settings, held for the whole layer
  typedef struct packed {
    logic signed [MULT_W-1:0]   mult;
    logic        [SHIFT_W-1:0]  shift;
    logic signed [OUT_BITS-1:0] zp;
  } quant_cfg_t;

endpackage

`default_nettype wire

//--- verilog/tile_pkg.sv
`default_nettype none

package tile_pkg;

  localparam int ADDR_W  = 16;
  localparam int COORD_W = 7;
  localparam int BLOCK_W = 7;
  localparam int GEOM_W  = 8;

  typedef logic [COORD_W-1:0] coord_t;
  typedef logic [BLOCK_W-1:0] block_t;

  // Where an item lands in the output map
  typedef struct packed {
    coord_t tile_row;
    coord_t col;
    block_t block;
  } tile_pos_t;

  // Output map size
  typedef struct packed {
    logic [GEOM_W-1:0] out_w;
    logic [GEOM_W-1:0] out_h;
    logic [GEOM_W-1:0] blocks;
  } geom_cfg_t;

  typedef struct packed {
    logic              en;
    logic [ADDR_W-1:0] addr;
  } wr_cmd_t;

endpackage

`default_nettype wire

//--- verilog/quant_decode.sv
`default_nettype none

module quant_decode
  import quant_pkg::*, tile_pkg::*;
#(
  parameter int LANES = 4
) (
  input  wire                                clk,
  input  wire                                rst_n,
  input  logic                               in_valid,
  input  acc_t      [LANES-1:0][N_CHAN-1:0]  in_sums,
  input  acc_t      [LANES-1:0]              in_bias,
  input  tile_pos_t                          in_pos,
  output logic      [N_CHAN-1:0]             ch_valid,
  output acc_t      [N_CHAN-1:0][LANES-1:0]  ch_sums,
  output acc_t      [N_CHAN-1:0][LANES-1:0]  ch_bias,
  output tile_pos_t [N_CHAN-1:0]             ch_pos
);

  // ========================================
  // Group capture
  // ========================================
  logic                               cap_valid;
  acc_t      [LANES-1:0][N_CHAN-1:0]  cap_sums;
  acc_t      [LANES-1:0]              cap_bias;
  tile_pos_t                          cap_pos;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cap_valid <= 1'b0;
    end else begin
      cap_valid <= in_valid;
    end
  end

  // Payload only loads on a strobe
  always_ff @(posedge clk) begin
    if (in_valid) begin
      cap_sums <= in_sums;
      cap_bias <= in_bias;
      cap_pos  <= in_pos;
    end
  end

  // ========================================
  // Per-channel select and stagger
  // ========================================
  for (genvar k = 0; k < N_CHAN; k++) begin : g_chan
    acc_t [LANES-1:0] sel_sums;
    tile_pos_t        sel_pos;

    // Row offset k of every unit, row moved down by k
    always_comb begin
      for (int u = 0; u < LANES; u++) begin
        sel_sums[u] = cap_sums[u][k];
      end
      sel_pos          = cap_pos;
      sel_pos.tile_row = cap_pos.tile_row + coord_t'(k);
    end

    if (k == 0) begin : g_direct
      assign ch_valid[k] = cap_valid;
      assign ch_sums[k]  = sel_sums;
      assign ch_bias[k]  = cap_bias;
      assign ch_pos[k]   = sel_pos;
    end else begin : g_stagger
      logic [k-1:0]     dly_valid;
      acc_t [LANES-1:0] dly_sums [k];
      acc_t [LANES-1:0] dly_bias [k];
      tile_pos_t        dly_pos  [k];

      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          dly_valid <= '0;
        end else begin
          dly_valid[0] <= cap_valid;
          for (int d = 1; d < k; d++) begin
            dly_valid[d] <= dly_valid[d-1];
          end
        end
      end

      always_ff @(posedge clk) begin
        dly_sums[0] <= sel_sums;
        dly_bias[0] <= cap_bias;
        dly_pos[0]  <= sel_pos;
        for (int d = 1; d < k; d++) begin
          dly_sums[d] <= dly_sums[d-1];
          dly_bias[d] <= dly_bias[d-1];
          dly_pos[d]  <= dly_pos[d-1];
        end
      end

      // k cycles behind channel 0
      assign ch_valid[k] = dly_valid[k-1];
      assign ch_sums[k]  = dly_sums[k-1];
      assign ch_bias[k]  = dly_bias[k-1];
      assign ch_pos[k]   = dly_pos[k-1];
    end
  end

endmodule

`default_nettype wire

//--- verilog/requant_execute.sv
`default_nettype none

module requant_execute
  import quant_pkg::*, tile_pkg::*;
#(
  parameter int LANES = 4
) (
  input  wire                     clk,
  input  wire                     rst_n,
  input  logic                    in_valid,
  input  acc_t      [LANES-1:0]   in_sums,
  input  acc_t      [LANES-1:0]   in_bias,
  input  tile_pos_t               in_pos,
  input  quant_cfg_t              cfg,
  output logic                    out_valid,
  output q_t        [LANES-1:0]   out_q,
  output tile_pos_t               out_pos
);

  // Round half up, shift, add zero point, clamp
  function automatic q_t requant(input prod_t prod, input quant_cfg_t c);
    wide_t wide;
    wide_t rnd;
    wide_t res;
    wide = wide_t'(prod);
    rnd  = '0;
    if (c.shift != '0) begin
      rnd = wide_t'(1) << (c.shift - 1'b1);
    end
    res = ((wide + rnd) >>> c.shift) + wide_t'($signed(c.zp));
    if (res > wide_t'(Q_MAX)) begin
      return q_t'(Q_MAX);
    end else if (res < wide_t'(Q_MIN)) begin
      return q_t'(Q_MIN);
    end
    return q_t'(res);
  endfunction

  // ========================================
  // Stage 1: bias and scale
  // ========================================
  acc_t  [LANES-1:0] bsum;
  logic              s1_valid;
  prod_t [LANES-1:0] s1_prod;
  tile_pos_t         s1_pos;

  // Bias add wraps at the accumulator width
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      bsum[l] = in_sums[l] + in_bias[l];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    for (int l = 0; l < LANES; l++) begin
      s1_prod[l] <= prod_t'(bsum[l]) * prod_t'($signed(cfg.mult));
    end
    s1_pos <= in_pos;
  end

  // ========================================
  // Stage 2: round, offset, saturate
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    for (int l = 0; l < LANES; l++) begin
      out_q[l] <= requant(s1_prod[l], cfg);
    end
    out_pos <= s1_pos;
  end

endmodule

`default_nettype wire

//--- verilog/write_result.sv
`default_nettype none

module write_result
  import quant_pkg::*, tile_pkg::*;
#(
  parameter int LANES = 4
) (
  input  wire                   clk,
  input  wire                   rst_n,
  input  logic                  in_valid,
  input  q_t        [LANES-1:0] in_q,
  input  tile_pos_t             in_pos,
  input  geom_cfg_t             geom,
  output wr_cmd_t               wr_cmd,
  output q_t        [LANES-1:0] wr_data
);

  logic [ADDR_W-1:0] addr_calc;
  logic              in_range;
  logic              do_write;

  // Row-major position, blocks innermost; only the low bits are kept
  assign addr_calc = ((ADDR_W'(in_pos.tile_row) * ADDR_W'(geom.out_w))
                      + ADDR_W'(in_pos.col)) * ADDR_W'(geom.blocks)
                     + ADDR_W'(in_pos.block);

  // Rows past the bottom edge or columns past the right edge are dropped
  assign in_range = (GEOM_W'(in_pos.tile_row) < geom.out_h) &&
                    (GEOM_W'(in_pos.col) < geom.out_w);

  assign do_write = in_valid && in_range;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_cmd  <= '0;
      wr_data <= '0;
    end else begin
      wr_cmd.en <= do_write;
      // Address and data hold across suppressed items
      if (do_write) begin
        wr_cmd.addr <= addr_calc;
        wr_data     <= in_q;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/quant_stream_top.sv
`default_nettype none

module quant_stream_top
  import quant_pkg::*, tile_pkg::*;
#(
  parameter int LANES = 4
) (
  input  wire                                clk,
  input  wire                                rst_n,
  input  logic                               in_valid,
  input  acc_t      [LANES-1:0][N_CHAN-1:0]  in_sums,
  input  acc_t      [LANES-1:0]              in_bias,
  input  tile_pos_t                          in_pos,
  input  quant_cfg_t                         quant_cfg,
  input  geom_cfg_t                          geom_cfg,
  output wr_cmd_t   [N_CHAN-1:0]             wr_cmd,
  output q_t        [N_CHAN-1:0][LANES-1:0]  wr_data
);

  logic      [N_CHAN-1:0]             dec_valid;
  acc_t      [N_CHAN-1:0][LANES-1:0]  dec_sums;
  acc_t      [N_CHAN-1:0][LANES-1:0]  dec_bias;
  tile_pos_t [N_CHAN-1:0]             dec_pos;

  quant_decode #(
    .LANES (LANES)
  ) u_decode (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_sums  (in_sums),
    .in_bias  (in_bias),
    .in_pos   (in_pos),
    .ch_valid (dec_valid),
    .ch_sums  (dec_sums),
    .ch_bias  (dec_bias),
    .ch_pos   (dec_pos)
  );

  // ========================================
  // One requantize/write pair per row channel
  // ========================================
  for (genvar k = 0; k < N_CHAN; k++) begin : g_chan
    logic             ex_valid;
    q_t   [LANES-1:0] ex_q;
    tile_pos_t        ex_pos;

    requant_execute #(
      .LANES (LANES)
    ) u_exec (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (dec_valid[k]),
      .in_sums   (dec_sums[k]),
      .in_bias   (dec_bias[k]),
      .in_pos    (dec_pos[k]),
      .cfg       (quant_cfg),
      .out_valid (ex_valid),
      .out_q     (ex_q),
      .out_pos   (ex_pos)
    );

    write_result #(
      .LANES (LANES)
    ) u_result (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_valid (ex_valid),
      .in_q     (ex_q),
      .in_pos   (ex_pos),
      .geom     (geom_cfg),
      .wr_cmd   (wr_cmd[k]),
      .wr_data  (wr_data[k])
    );
  end

endmodule

`default_nettype wire

//--- testbench/tb_quant_model.svh
`ifndef TB_QUANT_MODEL_SVH
`define TB_QUANT_MODEL_SVH

// ========================================
// Reference model
// ========================================

// Bias add wraps at 32 bits, then scale, round half up, offset, clamp
function automatic q_t model_requant(input acc_t acc, input acc_t bias,
                                     input quant_cfg_t cfg);
  acc_t   biased;
  longint val;
  biased = acc + bias;
  val    = longint'(biased) * longint'($signed(cfg.mult));
  // Half of the last kept step
  if (cfg.shift != 0) begin
    val = val + (longint'(1) << (cfg.shift - 1));
  end
  val = val >>> cfg.shift;
  val = val + longint'($signed(cfg.zp));
  if (val > 127) begin
    val = 127;
  end else if (val < -128) begin
    val = -128;
  end
  return q_t'(val);
endfunction

// Row-major, channel blocks innermost, low 16 bits
function automatic logic [ADDR_W-1:0] model_addr(input coord_t row, input coord_t col,
                                                  input block_t blk, input geom_cfg_t g);
  int unsigned full;
  full = ((int'(row) * int'(g.out_w)) + int'(col)) * int'(g.blocks) + int'(blk);
  return full[ADDR_W-1:0];
endfunction

function automatic bit model_in_range(input coord_t row, input coord_t col,
                                      input geom_cfg_t g);
  return (int'(row) < int'(g.out_h)) && (int'(col) < int'(g.out_w));
endfunction

`endif

//--- testbench/tb_quant_stream.sv
`default_nettype none

module tb_quant_stream
  import quant_pkg::*, tile_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int LANES      = 4;
  localparam int CLK_PERIOD = 100;
  localparam int N_STREAM   = 24;
  localparam int N_ROUND    = 5;
  localparam int N_BOUNDS   = 6;
  // Strobes over the whole run
  localparam int N_STROBES  = 1 + N_STREAM + 2 * N_ROUND + N_BOUNDS;
  localparam int MAX_CYCLES = 10 * N_STROBES + 50;

  `include "tb_quant_model.svh"

  typedef struct packed {
    logic [31:0]       due;
    logic [ADDR_W-1:0] addr;
    q_t   [LANES-1:0]  data;
  } exp_wr_t;

  logic                               clk;
  logic                               rst_n;
  logic                               in_valid;
  acc_t      [LANES-1:0][N_CHAN-1:0]  in_sums;
  acc_t      [LANES-1:0]              in_bias;
  tile_pos_t                          in_pos;
  quant_cfg_t                         quant_cfg;
  geom_cfg_t                          geom_cfg;
  wr_cmd_t   [N_CHAN-1:0]             wr_cmd;
  q_t        [N_CHAN-1:0][LANES-1:0]  wr_data;

  // Per-channel scoreboard and the values due in the current cycle
  exp_wr_t                        exp_q [N_CHAN][$];
  logic [N_CHAN-1:0]              exp_en;
  logic [N_CHAN-1:0][ADDR_W-1:0]  exp_addr;
  q_t   [N_CHAN-1:0][LANES-1:0]   exp_data;

  logic [31:0] cyc;
  logic        chk_on;
  int          seed;
  int          errors;
  int          test_errs;
  int          checked;
  string       test_name;

  int     rnd_mult  [N_ROUND] = '{1, 1, 3, -32768, 2047};
  int     rnd_shift [N_ROUND] = '{0, 1, 4, 20, 63};
  int     rnd_zp    [N_ROUND] = '{0, -3, 20, 10, -7};
  int     rnd_range [N_ROUND] = '{300, 400, 2000, 0, 0};
  coord_t bnd_row   [N_BOUNDS] = '{7'd6, 7'd7, 7'd8, 7'd2, 7'd5, 7'd1};
  coord_t bnd_col   [N_BOUNDS] = '{7'd4, 7'd9, 7'd0, 7'd10, 7'd3, 7'd12};

  quant_stream_top #(
    .LANES (LANES)
  ) UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_sums   (in_sums),
    .in_bias   (in_bias),
    .in_pos    (in_pos),
    .quant_cfg (quant_cfg),
    .geom_cfg  (geom_cfg),
    .wr_cmd    (wr_cmd),
    .wr_data   (wr_data)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  // ========================================
  // Scoreboard and checks
  // ========================================
  // Outputs are stable here; cyc already names the next rising edge
  always @(negedge clk) begin
    chk_on = 1'b1;
    for (int k = 0; k < N_CHAN; k++) begin
      exp_en[k] = 1'b0;
      if (exp_q[k].size() != 0 && exp_q[k][0].due == cyc) begin
        exp_en[k]   = 1'b1;
        exp_addr[k] = exp_q[k][0].addr;
        exp_data[k] = exp_q[k][0].data;
        void'(exp_q[k].pop_front());
        checked++;
      end
    end
  end

  for (genvar k = 0; k < N_CHAN; k++) begin : g_check
    assert property (@(posedge clk) chk_on |-> (wr_cmd[k].en == exp_en[k]))
      else begin
        errors++;
        $display("Error: %s ch%0d en expected %0b actual %0b", test_name, k,
                 $sampled(exp_en[k]), $sampled(wr_cmd[k].en));
      end
    assert property (@(posedge clk) chk_on |-> (wr_cmd[k].addr == exp_addr[k]))
      else begin
        errors++;
        $display("Error: %s ch%0d addr expected %h actual %h", test_name, k,
                 $sampled(exp_addr[k]), $sampled(wr_cmd[k].addr));
      end
    assert property (@(posedge clk) chk_on |-> (wr_data[k] == exp_data[k]))
      else begin
        errors++;
        $display("Error: %s ch%0d data expected %h actual %h", test_name, k,
                 $sampled(exp_data[k]), $sampled(wr_data[k]));
      end
  end

  // ========================================
  // Stimulus helpers
  // ========================================
  task automatic drive_group(input acc_t [LANES-1:0][N_CHAN-1:0] sums,
                             input acc_t [LANES-1:0] bias, input tile_pos_t pos);
    exp_wr_t e;
    coord_t  row;
    @(posedge clk);
    in_valid <= 1'b1;
    in_sums  <= sums;
    in_bias  <= bias;
    in_pos   <= pos;
    for (int k = 0; k < N_CHAN; k++) begin
      row = coord_t'(pos.tile_row + k);
      if (model_in_range(row, pos.col, geom_cfg)) begin
        // Sampled next edge, written 3+k edges later, seen one edge after
        e.due  = cyc + 5 + k;
        e.addr = model_addr(row, pos.col, pos.block, geom_cfg);
        for (int l = 0; l < LANES; l++) begin
          e.data[l] = model_requant(sums[l][k], bias[l], quant_cfg);
        end
        exp_q[k].push_back(e);
      end
    end
  endtask

  // range 0 means full 32-bit values
  task automatic random_group(input int range, output acc_t [LANES-1:0][N_CHAN-1:0] sums,
                              output acc_t [LANES-1:0] bias);
    for (int l = 0; l < LANES; l++) begin
      for (int k = 0; k < N_CHAN; k++) begin
        sums[l][k] = (range == 0) ? $random(seed) : $random(seed) % range;
      end
      bias[l] = (range == 0) ? $random(seed) : $random(seed) % range;
    end
  endtask

  // Keeps all four rows inside the fixed geometry
  task automatic random_pos(output tile_pos_t pos);
    pos.tile_row = coord_t'({$random(seed)} % 5);
    pos.col      = coord_t'({$random(seed)} % 10);
    pos.block    = block_t'({$random(seed)} % 3);
  endtask

  function automatic bit queues_busy();
    for (int k = 0; k < N_CHAN; k++) begin
      if (exp_q[k].size() != 0) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic drain();
    @(posedge clk);
    in_valid <= 1'b0;
    while (queues_busy()) begin
      @(posedge clk);
    end
    repeat (3) @(posedge clk);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = errors;
  endtask

  task automatic finish_test();
    $display("Test %-8s done, %0d errors", test_name, errors - test_errs);
  endtask

  // ========================================
  // Test sequence
  // ========================================
  initial begin
    acc_t      [LANES-1:0][N_CHAN-1:0] sums;
    acc_t      [LANES-1:0]             bias;
    tile_pos_t                         pos;
    seed      = 32'h5a00_8c60;
    clk       = 1'b0;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_sums   = '0;
    in_bias   = '0;
    in_pos    = '0;
    quant_cfg = '0;
    geom_cfg  = '{out_w: 8'd10, out_h: 8'd8, blocks: 8'd3};
    cyc       = '0;
    chk_on    = 1'b0;
    exp_en    = '0;
    exp_addr  = '0;
    exp_data  = '0;
    errors    = 0;
    checked   = 0;

    start_test("reset");
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    repeat (10) @(posedge clk);
    finish_test();

    start_test("single");
    @(posedge clk);
    quant_cfg <= '{mult: 16'sd5, shift: 6'd6, zp: 8'sd3};
    for (int l = 0; l < LANES; l++) begin
      for (int k = 0; k < N_CHAN; k++) begin
        sums[l][k] = acc_t'(900 * (k + 1) - 150 * l);
      end
      bias[l] = acc_t'(11 * l - 40);
    end
    pos = '{tile_row: 7'd2, col: 7'd3, block: 7'd1};
    drive_group(sums, bias, pos);
    drain();
    finish_test();

    start_test("stream");
    @(posedge clk);
    quant_cfg <= '{mult: 16'sd77, shift: 6'd12, zp: -8'sd4};
    for (int i = 0; i < N_STREAM; i++) begin
      random_group(20000, sums, bias);
      random_pos(pos);
      drive_group(sums, bias, pos);
    end
    drain();
    finish_test();

    start_test("round");
    for (int i = 0; i < N_ROUND; i++) begin
      @(posedge clk);
      quant_cfg.mult  <= 16'(rnd_mult[i]);
      quant_cfg.shift <= 6'(rnd_shift[i]);
      quant_cfg.zp    <= 8'(rnd_zp[i]);
      repeat (2) begin
        random_group(rnd_range[i], sums, bias);
        random_pos(pos);
        drive_group(sums, bias, pos);
      end
      drain();
    end
    finish_test();

    // High rows and wide columns fall off the output map
    start_test("bounds");
    @(posedge clk);
    quant_cfg <= '{mult: 16'sd9, shift: 6'd5, zp: 8'sd1};
    for (int i = 0; i < N_BOUNDS; i++) begin
      random_group(5000, sums, bias);
      pos = '{tile_row: bnd_row[i], col: bnd_col[i], block: 7'd2};
      drive_group(sums, bias, pos);
    end
    drain();
    finish_test();

    $display("%0d tests, %0d writes checked, %0d errors", 5, checked, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #(CLK_PERIOD * MAX_CYCLES);
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+testbench
verilog/quant_pkg.sv
verilog/tile_pkg.sv
verilog/quant_decode.sv
verilog/requant_execute.sv
verilog/write_result.sv
verilog/quant_stream_top.sv
testbench/tb_quant_stream.sv

//--- Bender.yml
package:
  name: quant_stream

sources:
  - files:
      - verilog/quant_pkg.sv
      - verilog/tile_pkg.sv
      - verilog/quant_decode.sv
      - verilog/requant_execute.sv
      - verilog/write_result.sv
      - verilog/quant_stream_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_quant_stream.sv
